// File: bitslice_pkg.sv
package bitslice_pkg;

	// ------------------------------------------------------------------
	// Widths that carry a meaning
	// ------------------------------------------------------------------

	// Data width of one slice.
	typedef logic [3:0] nib_t;

	// Address into the sixteen-entry register file of a slice.
	typedef logic [3:0] reg_addr_t;

	// Microinstruction with destination in 8..6, function in 5..3 and source in 2..0.
	typedef logic [8:0] micro_t;

	// ------------------------------------------------------------------
	// Field codes
	// ------------------------------------------------------------------

	// Destination codes select the register file and Q write-back.
	localparam logic [2:0] dst_qreg  = 3'b000;
	localparam logic [2:0] dst_nop   = 3'b001;
	localparam logic [2:0] dst_rama  = 3'b010;
	localparam logic [2:0] dst_ramf  = 3'b011;
	localparam logic [2:0] dst_ramqd = 3'b100;
	localparam logic [2:0] dst_ramd  = 3'b101;
	localparam logic [2:0] dst_ramqu = 3'b110;
	localparam logic [2:0] dst_ramu  = 3'b111;

	// ALU function codes.
	// The subtract names follow the usual convention, so subr is S minus R.
	localparam logic [2:0] fn_add   = 3'b000;
	localparam logic [2:0] fn_subr  = 3'b001;
	localparam logic [2:0] fn_subs  = 3'b010;
	localparam logic [2:0] fn_or    = 3'b011;
	localparam logic [2:0] fn_and   = 3'b100;
	localparam logic [2:0] fn_notrs = 3'b101;
	localparam logic [2:0] fn_exor  = 3'b110;
	localparam logic [2:0] fn_exnor = 3'b111;

	// Source pair codes, named as R operand then S operand.
	localparam logic [2:0] src_aq = 3'b000;
	localparam logic [2:0] src_ab = 3'b001;
	localparam logic [2:0] src_zq = 3'b010;
	localparam logic [2:0] src_zb = 3'b011;
	localparam logic [2:0] src_za = 3'b100;
	localparam logic [2:0] src_da = 3'b101;
	localparam logic [2:0] src_dq = 3'b110;
	localparam logic [2:0] src_dz = 3'b111;

	// States of the command front end.
	typedef enum logic [1:0] {
		idle,
		issue,
		hold
	} front_state_t;

endpackage

// File: slice_cmd_if.sv
`timescale 1ns/1ps

interface slice_cmd_if #(
	parameter int n_slices = 4
);
	import bitslice_pkg::*;

	// High for the single cycle in which the slices execute the command.
	logic issue;

	// Latched microinstruction and register file addresses.
	// All slices see the same fields.
	micro_t    instr;
	reg_addr_t a_addr;
	reg_addr_t b_addr;

	// External data word, one nibble per slice.
	nib_t [n_slices-1:0] d;

	// External carry-in, used only by the lookahead for slice 0.
	logic c0;

	// The front end drives every field.
	modport front (
		output issue, instr, a_addr, b_addr, d, c0
	);

	// Slices, lookahead and status collector only read.
	modport slice (
		input issue, instr, a_addr, b_addr, d, c0
	);

endinterface

// File: alu_slice.sv
`timescale 1ns/1ps

module alu_slice #(
	parameter int slice_idx = 0
) (
	input logic clk,
	slice_cmd_if.slice cmd,
	input logic cin,
	input logic ram_in_lo,
	input logic ram_in_hi,
	input logic q_in_lo,
	input logic q_in_hi,
	output bitslice_pkg::nib_t f,
	output logic c4,
	output logic ovr,
	output logic g_n,
	output logic p_n,
	output logic f_lsb,
	output logic f_msb,
	output logic q_lsb,
	output logic q_msb,
	output bitslice_pkg::nib_t a_out
);
	import bitslice_pkg::*;

	// Register file and Q register of this slice.
	nib_t ram [16];
	nib_t q;

	// Register file read ports, this slice's data nibble and the two operands.
	nib_t a, b, d_nib;
	nib_t r, s;

	// Microinstruction fields.
	logic [2:0] dst, fn, src;

	// Operands extended by one bit so that the top bit of the sum is the carry.
	logic [4:0] r_ext, s_ext, sum;

	// Bitwise generate and propagate of the operands as the adder sees them.
	logic [3:0] gen, prop;

	assign dst = cmd.instr[8:6];
	assign fn  = cmd.instr[5:3];
	assign src = cmd.instr[2:0];

	assign a     = ram[cmd.a_addr];
	assign b     = ram[cmd.b_addr];
	assign d_nib = cmd.d[slice_idx];

	// ------------------------------------------------------------------
	// Operand select
	// ------------------------------------------------------------------

	// R comes from the A port, from zero or from the external data.
	always_comb begin
		case (src)
			src_aq, src_ab:         r = a;
			src_zq, src_zb, src_za: r = '0;
			default:                r = d_nib;
		endcase
	end

	// S comes from the A port, the B port, Q or zero.
	always_comb begin
		case (src)
			src_za, src_da: s = a;
			src_ab, src_zb: s = b;
			src_dz:         s = '0;
			default:        s = q;
		endcase
	end

	// ------------------------------------------------------------------
	// ALU
	// ------------------------------------------------------------------

	// Subtraction inverts one operand and lets the carry-in add the one.
	assign r_ext = (fn == fn_subr) ? {1'b0, ~r} : {1'b0, r};
	assign s_ext = (fn == fn_subs) ? {1'b0, ~s} : {1'b0, s};

	// Logic functions leave the carry bit clear.
	always_comb begin
		case (fn)
			fn_add, fn_subr, fn_subs: sum = r_ext + s_ext + {4'b0000, cin};
			fn_or:                    sum = {1'b0, r | s};
			fn_and:                   sum = {1'b0, r & s};
			fn_notrs:                 sum = {1'b0, ~r & s};
			fn_exor:                  sum = {1'b0, r ^ s};
			default:                  sum = {1'b0, ~(r ^ s)};
		endcase
	end

	assign f  = sum[3:0];
	assign c4 = sum[4];

	// Overflow when both operands agree in sign and the sum does not.
	// Only the top slice's value means anything for the word.
	assign ovr = (r_ext[3] == s_ext[3]) && (r_ext[3] != sum[3]);

	// Group terms for the external lookahead, both active low.
	assign gen  = r_ext[3:0] & s_ext[3:0];
	assign prop = r_ext[3:0] | s_ext[3:0];
	assign p_n  = ~&prop;
	assign g_n  = ~(gen[3] |
		(prop[3] & gen[2]) |
		(prop[3] & prop[2] & gen[1]) |
		(prop[3] & prop[2] & prop[1] & gen[0]));

	// ------------------------------------------------------------------
	// Write-back
	// ------------------------------------------------------------------

	// The register at b_addr takes F, F shifted down or F shifted up.
	// A shift pulls the vacated bit from the neighbouring slice.
	always_ff @(posedge clk) begin
		if (cmd.issue) begin
			case (dst)
				dst_rama, dst_ramf:  ram[cmd.b_addr] <= f;
				dst_ramqd, dst_ramd: ram[cmd.b_addr] <= {ram_in_hi, f[3:1]};
				dst_ramqu, dst_ramu: ram[cmd.b_addr] <= {f[2:0], ram_in_lo};
				default: ;
			endcase
		end
	end

	// Q loads F or shifts together with the register file.
	always_ff @(posedge clk) begin
		if (cmd.issue) begin
			case (dst)
				dst_qreg:  q <= f;
				dst_ramqd: q <= {q_in_hi, q[3:1]};
				dst_ramqu: q <= {q[2:0], q_in_lo};
				default: ;
			endcase
		end
	end

	// Shift link outputs to the neighbours.
	assign f_lsb = f[0];
	assign f_msb = f[3];
	assign q_lsb = q[0];
	assign q_msb = q[3];

	// The A port is the word output for the rama destination.
	assign a_out = a;

	// An executed command must be fully known, or the write-back is garbage.
	a_instr_known: assert property (@(posedge clk) cmd.issue |-> !$isunknown(cmd.instr))
		else $error("alu_slice %0d: unknown instruction bits during issue", slice_idx);

endmodule

// File: cmd_front.sv
`timescale 1ns/1ps

module cmd_front #(
	parameter int n_slices = 4
) (
	input logic clk,
	input logic rst,
	input logic req,
	output logic ack,
	input bitslice_pkg::micro_t instr,
	input bitslice_pkg::reg_addr_t a_addr,
	input bitslice_pkg::reg_addr_t b_addr,
	input logic [n_slices*4-1:0] d,
	input logic c0,
	slice_cmd_if.front cmd
);
	import bitslice_pkg::*;

	front_state_t state;

	// ------------------------------------------------------------------
	// Handshake FSM
	// ------------------------------------------------------------------

	// Idle waits for req.
	// Issue lasts one cycle and executes the command.
	// Hold keeps ack up until the requester drops req.
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (req) begin
						state <= issue;
					end
				end
				issue: state <= hold;
				hold: begin
					if (!req) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// All fields are captured at the edge that leaves idle.
	// The requester may change its inputs afterwards.
	always_ff @(posedge clk) begin
		if (state == idle && req) begin
			cmd.instr  <= instr;
			cmd.a_addr <= a_addr;
			cmd.b_addr <= b_addr;
			cmd.d      <= d;
			cmd.c0     <= c0;
		end
	end

	assign cmd.issue = (state == issue);

	// Ack rises the edge after issue, when result and flags are registered.
	assign ack = (state == hold);

endmodule

// File: carry_lookahead.sv
`timescale 1ns/1ps

module carry_lookahead #(
	parameter int n_slices = 4
) (
	slice_cmd_if.slice cmd,
	input logic [n_slices-1:0] g_n,
	input logic [n_slices-1:0] p_n,
	output logic [n_slices-1:0] cin
);

	// ------------------------------------------------------------------
	// One-level group lookahead
	// ------------------------------------------------------------------

	// The carry into slice k is set when some lower slice generates and
	// every slice between it and k propagates, or when c0 is set and every
	// lower slice propagates.
	// The loop below nests that sum term by term and flattens into the
	// two-level equations of a lookahead generator.
	always_comb begin
		logic carry;
		carry = cmd.c0;
		for (int k = 0; k < n_slices; k++) begin
			cin[k] = carry;
			// Slice k either generates or passes the incoming carry on.
			carry = ~g_n[k] | (~p_n[k] & carry);
		end
	end

endmodule

// File: status_collect.sv
`timescale 1ns/1ps

module status_collect #(
	parameter int n_slices = 4
) (
	input logic clk,
	input logic rst,
	slice_cmd_if.slice cmd,
	input logic [n_slices*4-1:0] f_word,
	input logic [n_slices*4-1:0] a_word,
	input logic c4_top,
	input logic ovr_top,
	output logic [n_slices*4-1:0] result,
	output logic carry,
	output logic overflow,
	output logic zero,
	output logic sign
);
	import bitslice_pkg::*;

	// The rama destination puts the A port on the word output.
	logic sel_a;

	assign sel_a = (cmd.instr[8:6] == dst_rama);

	// ------------------------------------------------------------------
	// Result and flag registers
	// ------------------------------------------------------------------

	// Everything is captured at the edge that ends the issue cycle.
	// The values then hold until the next command.
	always_ff @(posedge clk) begin
		if (rst) begin
			result   <= '0;
			carry    <= 1'b0;
			overflow <= 1'b0;
			zero     <= 1'b0;
			sign     <= 1'b0;
		end else if (cmd.issue) begin
			result   <= sel_a ? a_word : f_word;
			carry    <= c4_top;
			overflow <= ovr_top;
			// Zero and sign always describe F, even when A is output.
			zero     <= (f_word == '0);
			sign     <= f_word[n_slices*4-1];
		end
	end

endmodule

// File: bitslice_top.sv
`timescale 1ns/1ps

module bitslice_top #(
	parameter int n_slices = 4
) (
	input logic clk,
	input logic rst,
	input logic req,
	output logic ack,
	input bitslice_pkg::micro_t instr,
	input bitslice_pkg::reg_addr_t a_addr,
	input bitslice_pkg::reg_addr_t b_addr,
	input logic [n_slices*4-1:0] d,
	input logic c0,
	input logic shift_fill,
	output logic [n_slices*4-1:0] result,
	output logic carry,
	output logic overflow,
	output logic zero,
	output logic sign
);

	// Word outputs gathered from the slices.
	logic [n_slices*4-1:0] f_word, a_word;

	// Per-slice carry terms and flags.
	logic [n_slices-1:0] g_n, p_n, cin, c4, ovr;

	// Per-slice shift link outputs.
	logic [n_slices-1:0] f_lsb, f_msb, q_lsb, q_msb;

	// Shift link inputs, index k feeds slice k.
	logic [n_slices-1:0] ram_hi, ram_lo, q_hi, q_lo;

	slice_cmd_if #(.n_slices(n_slices)) cmd_bus ();

	cmd_front #(.n_slices(n_slices)) u_front (
		.clk    (clk),
		.rst    (rst),
		.req    (req),
		.ack    (ack),
		.instr  (instr),
		.a_addr (a_addr),
		.b_addr (b_addr),
		.d      (d),
		.c0     (c0),
		.cmd    (cmd_bus)
	);

	// Down shifts take the lsb of the slice above, and the top slice takes the fill.
	assign ram_hi = {shift_fill, f_lsb[n_slices-1:1]};
	assign q_hi   = {shift_fill, q_lsb[n_slices-1:1]};

	// Up shifts take the msb of the slice below, and slice 0 takes the fill.
	assign ram_lo = {f_msb[n_slices-2:0], shift_fill};
	assign q_lo   = {q_msb[n_slices-2:0], shift_fill};

	for (genvar k = 0; k < n_slices; k++) begin : g_slice
		alu_slice #(.slice_idx(k)) u_slice (
			.clk       (clk),
			.cmd       (cmd_bus),
			.cin       (cin[k]),
			.ram_in_lo (ram_lo[k]),
			.ram_in_hi (ram_hi[k]),
			.q_in_lo   (q_lo[k]),
			.q_in_hi   (q_hi[k]),
			.f         (f_word[4*k +: 4]),
			.c4        (c4[k]),
			.ovr       (ovr[k]),
			.g_n       (g_n[k]),
			.p_n       (p_n[k]),
			.f_lsb     (f_lsb[k]),
			.f_msb     (f_msb[k]),
			.q_lsb     (q_lsb[k]),
			.q_msb     (q_msb[k]),
			.a_out     (a_word[4*k +: 4])
		);
	end

	carry_lookahead #(.n_slices(n_slices)) u_lookahead (
		.cmd (cmd_bus),
		.g_n (g_n),
		.p_n (p_n),
		.cin (cin)
	);

	// Word carry and overflow come from the most significant slice.
	status_collect #(.n_slices(n_slices)) u_status (
		.clk      (clk),
		.rst      (rst),
		.cmd      (cmd_bus),
		.f_word   (f_word),
		.a_word   (a_word),
		.c4_top   (c4[n_slices-1]),
		.ovr_top  (ovr[n_slices-1]),
		.result   (result),
		.carry    (carry),
		.overflow (overflow),
		.zero     (zero),
		.sign     (sign)
	);

endmodule

// File: tb_bitslice_model.svh
`ifndef tb_bitslice_model_svh
`define tb_bitslice_model_svh

// Word-level copy of the register file and of Q, kept in step with every command.
logic [15:0] model_ram [16];
logic [15:0] model_q;

// Expected outputs of the command in flight.
logic [15:0] exp_result;
logic exp_carry;
logic exp_ovr;
logic exp_zero;
logic exp_sign;

// Set for add and the two subtracts, where carry and overflow mean something.
logic exp_arith;

// ----------------------------------------------------------------------
// Prediction of one command
// ----------------------------------------------------------------------

// Works on the whole 16-bit word, then applies the write-back to the copies.
task automatic predict(input micro_t ins, input reg_addr_t aa, input reg_addr_t ba,
	input logic [15:0] dw, input logic cin0, input logic fill);
	logic [2:0] dst;
	logic [2:0] fn;
	logic [2:0] src;
	logic [15:0] r;
	logic [15:0] s;
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] f;
	logic [16:0] full;
	logic [16:0] wide;
	dst = ins[8:6];
	fn = ins[5:3];
	src = ins[2:0];
	// R is the A register, the data word or zero.
	case (src)
		src_aq, src_ab: r = model_ram[aa];
		src_da, src_dq, src_dz: r = dw;
		default: r = '0;
	endcase
	// S is Q, the B register, the A register or zero.
	case (src)
		src_aq, src_zq, src_dq: s = model_q;
		src_ab, src_zb: s = model_ram[ba];
		src_za, src_da: s = model_ram[aa];
		default: s = '0;
	endcase
	// A subtract adds the complement of the subtrahend, and c0 supplies the one.
	x = (fn == fn_subr) ? ~r : r;
	y = (fn == fn_subs) ? ~s : s;
	exp_arith = (fn == fn_add) || (fn == fn_subr) || (fn == fn_subs);
	case (fn)
		fn_or: full = {1'b0, r | s};
		fn_and: full = {1'b0, r & s};
		fn_notrs: full = {1'b0, ~r & s};
		fn_exor: full = {1'b0, r ^ s};
		fn_exnor: full = {1'b0, ~(r ^ s)};
		default: full = {1'b0, x} + {1'b0, y} + {16'd0, cin0};
	endcase
	f = full[15:0];
	exp_carry = full[16];
	// The signed sum overflows when it needs a seventeenth bit to keep its sign.
	wide = {x[15], x} + {y[15], y} + {16'd0, cin0};
	exp_ovr = (wide[16] != wide[15]);
	exp_zero = (f == 16'd0);
	exp_sign = f[15];
	// The A port shows the old register contents, read before the write.
	exp_result = (dst == dst_rama) ? model_ram[aa] : f;
	case (dst)
		dst_rama, dst_ramf: model_ram[ba] = f;
		dst_ramqd, dst_ramd: model_ram[ba] = {fill, f[15:1]};
		dst_ramqu, dst_ramu: model_ram[ba] = {f[14:0], fill};
		default: ;
	endcase
	case (dst)
		dst_qreg: model_q = f;
		dst_ramqd: model_q = {fill, model_q[15:1]};
		dst_ramqu: model_q = {model_q[14:0], fill};
		default: ;
	endcase
endtask

`endif

// File: tb_bitslice_top.sv
`timescale 1ns/1ps

module tb_bitslice_top;
	import bitslice_pkg::*;

	// Each command takes three cycles, so eight per command leaves plenty of room.
	localparam int n_cmds = 300;
	localparam int cycle_limit = n_cmds * 8 + 100;

	logic clk;
	logic rst;
	logic req;
	logic ack;
	micro_t instr;
	reg_addr_t a_addr;
	reg_addr_t b_addr;
	logic [15:0] d;
	logic c0;
	logic shift_fill;
	logic [15:0] result;
	logic carry;
	logic overflow;
	logic zero;
	logic sign;

	logic [15:0] lfsr;
	int cycles = 0;
	string test_name = "reset";

	`include "tb_bitslice_model.svh"

	bitslice_top #(.n_slices(4)) dut0 (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.ack        (ack),
		.instr      (instr),
		.a_addr     (a_addr),
		.b_addr     (b_addr),
		.d          (d),
		.c0         (c0),
		.shift_fill (shift_fill),
		.result     (result),
		.carry      (carry),
		.overflow   (overflow),
		.zero       (zero),
		.sign       (sign)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Failure handling and random numbers
	// ----------------------------------------------------------------------

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic show_mismatch(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		$display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
		abort_run();
	endtask

	task automatic fail_run(input string why);
		$display("%s", why);
		abort_run();
	endtask

	// Galois form of x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken.
	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// ----------------------------------------------------------------------
	// Handshake driver
	// ----------------------------------------------------------------------

	// Entered on a falling edge with ack low, and left the same way.
	task automatic send_cmd(input micro_t ins, input reg_addr_t aa, input reg_addr_t ba,
		input logic [15:0] dw, input logic cin0, input logic fill, input string name);
		logic [15:0] waited;
		waited = 16'd0;
		test_name = name;
		predict(ins, aa, ba, dw, cin0, fill);
		instr = ins;
		a_addr = aa;
		b_addr = ba;
		d = dw;
		c0 = cin0;
		shift_fill = fill;
		req = 1'b1;
		do begin
			@(negedge clk);
			waited = waited + 16'd1;
		end while (ack !== 1'b1);
		// Seen at edge N, issue until N+1, then ack.
		assert (waited == 16'd2)
			else show_mismatch({name, " ack latency"}, 16'd2, waited);
		req = 1'b0;
		@(negedge clk);
		assert (ack === 1'b0)
			else fail_run({name, ": ack still high one cycle after req dropped"});
	endtask

	// ----------------------------------------------------------------------
	// Output checks
	// ----------------------------------------------------------------------

	// Outputs are registered, so the falling edge sees them settled.
	always @(negedge clk) begin
		if (rst) begin
			assert (ack === 1'b0) else fail_run("ack is not low during reset");
		end else if (ack === 1'b1) begin
			assert (result === exp_result)
				else show_mismatch({test_name, " result"}, exp_result, result);
			assert (zero === exp_zero)
				else show_mismatch({test_name, " zero"}, {15'd0, exp_zero}, {15'd0, zero});
			assert (sign === exp_sign)
				else show_mismatch({test_name, " sign"}, {15'd0, exp_sign}, {15'd0, sign});
			if (exp_arith) begin
				assert (carry === exp_carry)
					else show_mismatch({test_name, " carry"}, {15'd0, exp_carry},
						{15'd0, carry});
				assert (overflow === exp_ovr)
					else show_mismatch({test_name, " overflow"}, {15'd0, exp_ovr},
						{15'd0, overflow});
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			fail_run("timeout: the command sequence did not finish in time");
		end
	end

	// ----------------------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------------------

	initial begin
		logic [31:0] v;
		micro_t ins;
		reg_addr_t aa;
		reg_addr_t ba;
		logic [15:0] dw;
		logic cin0;
		logic fill;
		rst = 1'b1;
		req = 1'b0;
		instr = '0;
		a_addr = '0;
		b_addr = '0;
		d = '0;
		c0 = 1'b0;
		shift_fill = 1'b0;
		lfsr = 16'd64620;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		// D plus zero into every register, so nothing read later is unknown.
		for (int k = 0; k < 16; k++) begin
			take_bits(16, v);
			send_cmd({dst_ramf, fn_add, src_dz}, k[3:0], k[3:0], v[15:0], 1'b0, 1'b0,
				$sformatf("load r%0d", k));
		end
		take_bits(16, v);
		send_cmd({dst_qreg, fn_add, src_dz}, 4'd0, 4'd0, v[15:0], 1'b0, 1'b0, "load q");
		// Fully random commands reach the arithmetic, logic, readback and shift cases.
		for (int i = 17; i < n_cmds; i++) begin
			take_bits(9, v);
			ins = v[8:0];
			take_bits(4, v);
			aa = v[3:0];
			take_bits(4, v);
			ba = v[3:0];
			take_bits(16, v);
			dw = v[15:0];
			take_bits(1, v);
			cin0 = v[0];
			take_bits(1, v);
			fill = v[0];
			send_cmd(ins, aa, ba, dw, cin0, fill, $sformatf("cmd %0d dst %0d fn %0d src %0d",
				i, ins[8:6], ins[5:3], ins[2:0]));
		end
		@(negedge clk);
		$display("All checks passed");
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
bitslice_pkg.sv
slice_cmd_if.sv
alu_slice.sv
cmd_front.sv
carry_lookahead.sv
status_collect.sv
bitslice_top.sv
tb_bitslice_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_bitslice_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "All checks passed" $(LOG); then echo "test: PASS"; \
	else echo "test: FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
